// ==== rtl/rh11_pkg.sv ====
// RH-11 / RP disk controller shared definitions
// register map, field positions, constant words and the structs passed between blocks

package rh11_pkg;

    localparam int BUS_ADDR_W  = 18;
    localparam int WORD_W      = 16;
    localparam int NUM_DRIVES  = 8;
    localparam int DRIVE_W     = 3;
    localparam int REG_SEL_W   = 5;
    localparam int FUNC_W      = 6;    // function code including GO
    localparam int LA_SECTOR_W = 8;

    localparam logic [BUS_ADDR_W-1:0] RH_BASE_ADDR = 18'o776700;

    // register numbers, word address bits 5:1
    localparam logic [REG_SEL_W-1:0] REG_CS1 = 5'd0;
    localparam logic [REG_SEL_W-1:0] REG_WC  = 5'd1;
    localparam logic [REG_SEL_W-1:0] REG_BA  = 5'd2;
    localparam logic [REG_SEL_W-1:0] REG_DA  = 5'd3;
    localparam logic [REG_SEL_W-1:0] REG_CS2 = 5'd4;
    localparam logic [REG_SEL_W-1:0] REG_DS  = 5'd5;
    localparam logic [REG_SEL_W-1:0] REG_ER1 = 5'd6;
    localparam logic [REG_SEL_W-1:0] REG_AS  = 5'd7;
    localparam logic [REG_SEL_W-1:0] REG_LA  = 5'd8;
    localparam logic [REG_SEL_W-1:0] REG_DT  = 5'd11;
    localparam logic [REG_SEL_W-1:0] REG_SN  = 5'd12;
    localparam logic [REG_SEL_W-1:0] REG_OF  = 5'd13;
    localparam logic [REG_SEL_W-1:0] REG_DC  = 5'd14;

    localparam logic [FUNC_W-1:0] FUNC_PACK_ACK = 6'o23;
    localparam int FUNC_XFER = 5;      // codes 51 and up move data

    // bit positions
    localparam int CS1_TRE  = 14;      // writing a one here clears controller errors
    localparam int CS1_MCPE = 13;
    localparam int CS1_IE   = 6;
    localparam int CS2_PGE  = 10;
    localparam int CS2_MDPE = 8;
    localparam int CS2_CLR  = 5;
    localparam int DS_ERR   = 14;
    localparam int DS_DRY   = 7;
    localparam int DS_VV    = 6;

    localparam logic [WORD_W-1:0] DS_RESET          = 16'o010600;  // MOL, DPR, DRY
    localparam logic [WORD_W-1:0] DRIVE_TYPE_WORD   = 16'o020022;  // RP06
    localparam logic [WORD_W-1:0] DRIVE_SERIAL_WORD = 16'h1234;
    localparam logic [WORD_W-1:0] OFFSET_WORD       = 16'o010000;  // 16-bit format

    localparam int SECTORS_PER_TRACK = 22;
    localparam int QTR_SECTOR_CYCLES = 6;    // short, real drives are far slower
    localparam int QTR_TICK_W        = $clog2(QTR_SECTOR_CYCLES);

    typedef struct packed {
        logic                 write;
        logic [REG_SEL_W-1:0] sel;
        logic                 wr_hi;
        logic                 wr_lo;
        logic [WORD_W-1:0]    data;
    } bus_access_t;

    typedef struct packed {
        logic [DRIVE_W-1:0]    drive;
        logic [FUNC_W-1:0]     func;
        logic [WORD_W-1:0]     da;
        logic [WORD_W-1:0]     dc;
        logic [WORD_W-1:0]     wc;
        logic [BUS_ADDR_W-1:0] ba;       // A17, A16 from CS1 on top
    } disk_cmd_t;

    typedef struct packed {
        logic [DRIVE_W-1:0] drive;
        logic               error;
    } cmd_done_t;

    typedef struct packed {
        logic [WORD_W-1:0] ds;
        logic [WORD_W-1:0] da;
        logic [WORD_W-1:0] dc;
        logic [WORD_W-1:0] er1;
        logic              attn;
    } drive_view_t;

    // byte-lane write into a register word
    function automatic logic [WORD_W-1:0] byte_merge(input logic [WORD_W-1:0] old_word,
                                                      input logic [WORD_W-1:0] new_word,
                                                      input logic hi,
                                                      input logic lo);
        byte_merge = old_word;
        if (hi) byte_merge[15:8] = new_word[15:8];
        if (lo) byte_merge[7:0] = new_word[7:0];
    endfunction

endpackage

// ==== rtl/rh11_bus_decode.sv ====
// RH-11 UNIBUS slave front end
// matches the register block address, decodes byte lanes and runs MSYN/SSYN

`timescale 1ns/100ps

module rh11_bus_decode
    import rh11_pkg::*;
(
    input  logic                  CLOCK,
    input  logic                  RESET,
    input  logic [BUS_ADDR_W-1:0] a_in,
    input  logic [1:0]            c_in,
    input  logic [WORD_W-1:0]     d_in,
    input  logic                  msyn,
    output logic                  ssyn,
    output logic                  access_valid,
    output bus_access_t           access
);

    logic hit;
    logic byte_op;

    // block is 32 words, so bits 17:6 pick it out
    assign hit     = (a_in[BUS_ADDR_W-1:REG_SEL_W+1] == RH_BASE_ADDR[BUS_ADDR_W-1:REG_SEL_W+1]);
    assign byte_op = c_in[0];                   // DATOB, only meaningful on writes

    // taken only while ssyn is low, so one pulse per bus cycle
    assign access_valid = msyn & hit & ~ssyn;

    always_comb begin
        access.write = c_in[1];                 // DATO / DATOB
        access.sel   = a_in[REG_SEL_W:1];
        access.wr_hi = ~byte_op | a_in[0];      // odd byte address
        access.wr_lo = ~byte_op | ~a_in[0];
        access.data  = d_in;
    end

    always_ff @(posedge CLOCK) begin
        if (RESET) begin
            ssyn <= 1'b0;
        end else if (access_valid) begin
            ssyn <= 1'b1;
        end else if (~msyn) begin
            ssyn <= 1'b0;                       // master let go, finish the cycle
        end
    end

endmodule

// ==== rtl/rh11_command.sv ====
// RH-11 controller registers and command execution
// holds CS1, WC, BA, CS2, checks GO and runs the command and completion channels

`timescale 1ns/100ps

module rh11_command
    import rh11_pkg::*;
(
    input  logic               CLOCK,
    input  logic               RESET,
    input  logic               access_valid,
    input  bus_access_t        access,
    output logic [DRIVE_W-1:0] sel_drive,
    input  drive_view_t        drive,
    output logic               start_drive,
    output logic               pack_ack,
    output logic               clear_all,
    output logic [WORD_W-1:0]  cs1_word,
    output logic [WORD_W-1:0]  wc_word,
    output logic [WORD_W-1:0]  ba_word,
    output logic [WORD_W-1:0]  cs2_word,
    output logic               cmd_valid,
    input  logic               cmd_ready,
    output disk_cmd_t          cmd,
    input  logic               done_valid,
    output logic               done_ready,
    input  cmd_done_t          done,
    output logic               finish_valid,
    output cmd_done_t          finish
);

    logic [FUNC_W-1:0]  func;
    logic [1:0]         ba_ext;         // A17, A16
    logic               psel;
    logic               rdy;
    logic               ie;
    logic [WORD_W-1:0]  wc;
    logic [WORD_W-1:0]  ba;
    logic [WORD_W-1:0]  cs2;
    logic [DRIVE_W-1:0] xfer_drive;     // drive owning the current data transfer
    logic               wr;
    logic               go_write;
    logic               go_fail;
    logic               go_ok;
    logic               is_xfer;
    logic [1:0]         next_ext;

    assign sel_drive = cs2[DRIVE_W-1:0];

    assign wr       = access_valid & access.write;
    assign go_write = wr & access.wr_lo & (access.sel == REG_CS1) & access.data[0];
    assign is_xfer  = access.data[FUNC_XFER];

    // drive must be ready, a transfer needs the controller too, and a command
    // still waiting in the channel counts as busy
    assign go_fail = ~drive.ds[DS_DRY] | (is_xfer & ~rdy) | cmd_valid;
    assign go_ok   = go_write & ~go_fail;

    assign pack_ack    = go_ok & (access.data[FUNC_W-1:0] == FUNC_PACK_ACK);
    assign start_drive = go_ok & ~pack_ack;
    assign clear_all   = wr & access.wr_lo & (access.sel == REG_CS2) & access.data[CS2_CLR];

    assign next_ext = access.wr_hi ? access.data[9:8] : ba_ext;   // same write may set A17/A16

    // completions wait while a bus access is being applied
    assign done_ready   = ~access_valid;
    assign finish_valid = done_valid & done_ready;
    assign finish       = done;

    // SC and TRE are filled in by the read path
    assign cs1_word = {4'b0000, 1'b1, psel, ba_ext, rdy, ie, func};
    assign wc_word  = wc;
    assign ba_word  = ba;
    assign cs2_word = cs2;

    always_ff @(posedge CLOCK) begin
        if (RESET | clear_all) begin
            func       <= '0;
            ba_ext     <= '0;
            psel       <= 1'b0;
            rdy        <= 1'b1;
            ie         <= 1'b0;
            wc         <= '0;
            ba         <= '0;
            cs2        <= '0;
            xfer_drive <= '0;
        end else if (wr) begin
            case (access.sel)
                REG_CS1: begin
                    if (access.wr_hi) begin
                        if (access.data[CS1_TRE]) begin
                            cs2[15:8] <= '0;
                        end
                        psel   <= access.data[10];
                        ba_ext <= access.data[9:8];
                    end
                    if (access.wr_lo) begin
                        ie <= access.data[CS1_IE];
                        if (~go_write | go_ok) func <= access.data[FUNC_W-1:0];
                        if (go_write & go_fail) cs2[CS2_PGE] <= 1'b1;
                        if (start_drive & is_xfer) begin
                            rdy        <= 1'b0;
                            cs2[15:8]  <= '0;     // new transfer starts clean
                            xfer_drive <= sel_drive;
                        end
                    end
                end
                REG_WC:  wc <= byte_merge(wc, access.data, access.wr_hi, access.wr_lo);
                REG_BA:  ba <= byte_merge(ba, {access.data[15:1], 1'b0},
                                          access.wr_hi, access.wr_lo);
                REG_CS2: if (access.wr_lo) cs2[4:0] <= access.data[4:0];   // unit, BAI, PAT
                default: ;
            endcase
        end else if (finish_valid & ~rdy & (done.drive == xfer_drive)) begin
            rdy <= 1'b1;                                   // transfer finished
            if (done.error) cs2[CS2_MDPE] <= 1'b1;
        end
    end

    always_ff @(posedge CLOCK) begin
        if (RESET) begin
            cmd_valid <= 1'b0;
        end else if (start_drive) begin
            cmd_valid <= 1'b1;
        end else if (cmd_ready) begin
            cmd_valid <= 1'b0;
        end
    end

    // payload only loads when the channel is empty
    always_ff @(posedge CLOCK) begin
        if (start_drive) begin
            cmd.drive <= sel_drive;
            cmd.func  <= access.data[FUNC_W-1:0];
            cmd.da    <= drive.da;
            cmd.dc    <= drive.dc;
            cmd.wc    <= wc;
            cmd.ba    <= {next_ext, ba};
        end
    end

endmodule

// ==== rtl/rh11_drive_regs.sv ====
// RH-11 per-drive registers for eight drives
// DA, DC, DS and ER1 per unit plus the attention summary

`timescale 1ns/100ps

module rh11_drive_regs
    import rh11_pkg::*;
(
    input  logic                  CLOCK,
    input  logic                  RESET,
    input  logic                  access_valid,
    input  bus_access_t           access,
    input  logic [DRIVE_W-1:0]    sel_drive,
    input  logic                  start_drive,
    input  logic                  pack_ack,
    input  logic                  clear_all,
    input  logic                  finish_valid,
    input  cmd_done_t             finish,
    output drive_view_t           drive,
    output logic [NUM_DRIVES-1:0] attn_summary
);

    logic [WORD_W-1:0]     da_q  [NUM_DRIVES];
    logic [WORD_W-1:0]     dc_q  [NUM_DRIVES];
    logic [WORD_W-1:0]     ds_q  [NUM_DRIVES];
    logic [WORD_W-1:0]     er1_q [NUM_DRIVES];
    logic [NUM_DRIVES-1:0] attn_q;
    logic                  wr;

    assign wr = access_valid & access.write;

    // disk and cylinder address, plain storage
    always_ff @(posedge CLOCK) begin
        if (wr & (access.sel == REG_DA))
            da_q[sel_drive] <= byte_merge(da_q[sel_drive], access.data,
                                          access.wr_hi, access.wr_lo);
        if (wr & (access.sel == REG_DC))
            dc_q[sel_drive] <= byte_merge(dc_q[sel_drive], access.data,
                                          access.wr_hi, access.wr_lo);
    end

    always_ff @(posedge CLOCK) begin
        if (RESET | clear_all) begin
            for (int i = 0; i < NUM_DRIVES; i++) begin
                ds_q[i]  <= DS_RESET;
                er1_q[i] <= '0;
            end
            attn_q <= '0;
        end else begin
            if (wr & (access.sel == REG_ER1))
                er1_q[sel_drive] <= byte_merge(er1_q[sel_drive], access.data,
                                               access.wr_hi, access.wr_lo);
            if (wr & (access.sel == REG_AS) & access.wr_lo)
                attn_q <= attn_q & ~access.data[NUM_DRIVES-1:0];   // write one to clear
            if (start_drive) begin
                ds_q[sel_drive][DS_DRY] <= 1'b0;                  // drive now busy
                ds_q[sel_drive][DS_ERR] <= 1'b0;
            end
            if (pack_ack)
                ds_q[sel_drive][DS_VV] <= 1'b1;
            // never in the same cycle as a bus access
            if (finish_valid) begin
                ds_q[finish.drive][DS_DRY] <= 1'b1;
                if (finish.error) ds_q[finish.drive][DS_ERR] <= 1'b1;
                attn_q[finish.drive] <= 1'b1;
            end
        end
    end

    always_comb begin
        drive.ds   = ds_q[sel_drive];
        drive.da   = da_q[sel_drive];
        drive.dc   = dc_q[sel_drive];
        drive.er1  = er1_q[sel_drive];
        drive.attn = attn_q[sel_drive];
    end

    assign attn_summary = attn_q;

endmodule

// ==== rtl/rh11_sector_counter.sv ====
// RH-11 look-ahead counter, tracks the sector passing under the heads

`timescale 1ns/100ps

module rh11_sector_counter
    import rh11_pkg::*;
(
    input  logic              CLOCK,
    input  logic              RESET,
    output logic [WORD_W-1:0] la_word
);

    logic [QTR_TICK_W-1:0]  tick;
    logic [1:0]             qtr;        // quarter sector
    logic [LA_SECTOR_W-1:0] sector;

    always_ff @(posedge CLOCK) begin
        if (RESET) begin
            tick   <= '0;
            qtr    <= '0;
            sector <= '0;
        end else if (tick != QTR_TICK_W'(QTR_SECTOR_CYCLES - 1)) begin
            tick <= tick + 1'b1;
        end else begin
            tick <= '0;
            qtr  <= qtr + 1'b1;          // wraps by itself
            if (qtr == 2'd3)
                sector <= (sector == LA_SECTOR_W'(SECTORS_PER_TRACK - 1)) ? '0 : sector + 1'b1;
        end
    end

    assign la_word = {2'b00, sector, qtr, 4'b0000};

endmodule

// ==== rtl/rh11_read_mux.sv ====
// RH-11 register read path
// returns the registered read word for the selected register and drive

`timescale 1ns/100ps

module rh11_read_mux
    import rh11_pkg::*;
(
    input  logic                  CLOCK,
    input  logic                  RESET,
    input  logic                  access_valid,
    input  bus_access_t           access,
    input  logic [WORD_W-1:0]     cs1_word,
    input  logic [WORD_W-1:0]     wc_word,
    input  logic [WORD_W-1:0]     ba_word,
    input  logic [WORD_W-1:0]     cs2_word,
    input  drive_view_t           drive,
    input  logic [NUM_DRIVES-1:0] attn_summary,
    input  logic [WORD_W-1:0]     la_word,
    output logic [WORD_W-1:0]     d_out
);

    logic tre;
    logic sc;

    assign tre = |cs2_word[15:8];                                   // any CS2 error
    assign sc  = tre | cs1_word[CS1_MCPE] | (|attn_summary);

    always_ff @(posedge CLOCK) begin
        if (RESET) begin
            d_out <= '0;
        end else if (access_valid) begin
            if (access.write) begin
                d_out <= '0;
            end else begin
                case (access.sel)
                    REG_CS1: d_out <= {sc, tre, cs1_word[13:0]};
                    REG_WC:  d_out <= wc_word;
                    REG_BA:  d_out <= ba_word;
                    REG_DA:  d_out <= drive.da;
                    REG_CS2: d_out <= cs2_word;
                    REG_DS:  d_out <= {drive.attn, drive.ds[14:0]};  // ATA on top
                    REG_ER1: d_out <= drive.er1;
                    REG_AS:  d_out <= {{(WORD_W - NUM_DRIVES){1'b0}}, attn_summary};
                    REG_LA:  d_out <= la_word;
                    REG_DT:  d_out <= DRIVE_TYPE_WORD;
                    REG_SN:  d_out <= DRIVE_SERIAL_WORD;
                    REG_OF:  d_out <= OFFSET_WORD;
                    REG_DC:  d_out <= drive.dc;
                    default: d_out <= '0;                          // unimplemented reads as zero
                endcase
            end
        end
    end

endmodule

// ==== rtl/rh11_top.sv ====
// RH-11 / RP controller register file, top level
// UNIBUS slave side plus command and completion channels to a disk engine

`timescale 1ns/100ps

module rh11_top
    import rh11_pkg::*;
(
    input  logic                  CLOCK,
    input  logic                  RESET,
    input  logic [BUS_ADDR_W-1:0] a_in,
    input  logic [1:0]            c_in,
    input  logic [WORD_W-1:0]     d_in,
    input  logic                  msyn,
    output logic [WORD_W-1:0]     d_out,
    output logic                  ssyn,
    output logic                  cmd_valid,
    input  logic                  cmd_ready,
    output disk_cmd_t             cmd,
    input  logic                  done_valid,
    output logic                  done_ready,
    input  cmd_done_t             done
);

    // port names match across blocks, so implicit connections are used
    logic                  access_valid;
    bus_access_t           access;
    logic [DRIVE_W-1:0]    sel_drive;
    drive_view_t           drive;
    logic                  start_drive;
    logic                  pack_ack;
    logic                  clear_all;
    logic [WORD_W-1:0]     cs1_word;
    logic [WORD_W-1:0]     wc_word;
    logic [WORD_W-1:0]     ba_word;
    logic [WORD_W-1:0]     cs2_word;
    logic                  finish_valid;
    cmd_done_t             finish;
    logic [NUM_DRIVES-1:0] attn_summary;
    logic [WORD_W-1:0]     la_word;

    rh11_bus_decode u_bus_decode (.*);

    rh11_command u_command (.*);

    rh11_drive_regs u_drive_regs (.*);

    rh11_sector_counter u_sector_counter (.*);

    rh11_read_mux u_read_mux (.*);

endmodule

// ==== verification/rh11_assertions.sv ====
// RH-11 handshake assertions, bound to the top level

`timescale 1ns/100ps

module rh11_assertions
    import rh11_pkg::*;
(
    input logic      CLOCK,
    input logic      RESET,
    input logic      msyn,
    input logic      ssyn,
    input logic      cmd_valid,
    input logic      cmd_ready,
    input disk_cmd_t cmd
);

    // command waits unchanged under back-pressure
    cmd_hold: assert property (@(posedge CLOCK) disable iff (RESET)
        cmd_valid && !cmd_ready |=> cmd_valid && $stable(cmd))
        else $error("command changed while waiting for ready");

    ssyn_release: assert property (@(posedge CLOCK) disable iff (RESET)
        $fell(ssyn) |-> $past(!msyn))
        else $error("ssyn dropped while msyn still high");

    cmd_after_reset: assert property (@(posedge CLOCK) $fell(RESET) |-> !cmd_valid)
        else $error("cmd_valid high after reset");

endmodule

bind rh11_top rh11_assertions u_assertions (.*);

// ==== verification/tb_rh11.sv ====
// RH-11 register file testbench
// drives UNIBUS cycles, plays the disk engine and checks against a register model

`timescale 1ns/100ps

module tb_rh11;
    import rh11_pkg::*;

    localparam int BUS_OPS        = 47;     // bus cycles in the tests below
    localparam int CYCLES_PER_OP  = 8;
    localparam int COMPLETIONS    = 2;
    localparam int MAX_DONE_DELAY = 88;     // 24 plus six random bits
    localparam int LIMIT_CYCLES   = 2 * (BUS_OPS * CYCLES_PER_OP + COMPLETIONS * MAX_DONE_DELAY);

    logic                  CLOCK;
    logic                  RESET;
    logic [BUS_ADDR_W-1:0] a_in;
    logic [1:0]            c_in;
    logic [WORD_W-1:0]     d_in;
    logic                  msyn;
    logic [WORD_W-1:0]     d_out;
    logic                  ssyn;
    logic                  cmd_valid;
    logic                  cmd_ready;
    disk_cmd_t             cmd;
    logic                  done_valid;
    logic                  done_ready;
    cmd_done_t             done;

    // register model
    logic [WORD_W-1:0]     m_wc;
    logic [WORD_W-1:0]     m_ba;
    logic [WORD_W-1:0]     m_da [NUM_DRIVES];
    logic [WORD_W-1:0]     m_dc [NUM_DRIVES];
    logic [WORD_W-1:0]     m_ds [NUM_DRIVES];
    logic [NUM_DRIVES-1:0] m_attn;
    logic [DRIVE_W-1:0]    m_unit;
    logic                  m_pge;

    logic [31:0]           lfsr_state = 32'he236;
    disk_cmd_t             cmd_log[$];
    logic [DRIVE_W-1:0]    pend_drive[$];
    int                    pend_wait[$];
    int                    done_count = 0;
    logic [WORD_W-1:0]     exp_q[$];
    logic [WORD_W-1:0]     act_q[$];
    string                 name_q[$];
    int                    errors = 0;
    int                    checks = 0;
    int                    tests = 0;
    int                    test_start_errors = 0;

    rh11_top u_dut (.*);

    always #2 CLOCK = ~CLOCK;

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
    function automatic logic lfsr_bit();
        lfsr_state = {lfsr_state[30:0],
                      lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
        return lfsr_state[0];
    endfunction

    function automatic logic [7:0] draw_bits(input int n);
        logic [7:0] r;
        r = '0;
        for (int i = 0; i < n; i++) r = {r[6:0], lfsr_bit()};
        return r;
    endfunction

    function automatic logic [WORD_W-1:0] merge(input logic [WORD_W-1:0] old_w,
                                                input logic [WORD_W-1:0] new_w,
                                                input logic hi, input logic lo);
        return {hi ? new_w[15:8] : old_w[15:8], lo ? new_w[7:0] : old_w[7:0]};
    endfunction

    // reference read value of a register
    function automatic logic [WORD_W-1:0] expected_word(input logic [REG_SEL_W-1:0] sel);
        case (sel)
            REG_WC:  return m_wc;
            REG_BA:  return m_ba;
            REG_DA:  return m_da[m_unit];
            REG_DC:  return m_dc[m_unit];
            REG_CS2: return {5'b0, m_pge, 7'b0, m_unit};
            REG_DS:  return {m_attn[m_unit], m_ds[m_unit][14:0]};
            REG_AS:  return {8'b0, m_attn};
            default: return '0;
        endcase
    endfunction

    function automatic disk_cmd_t expected_cmd(input logic [FUNC_W-1:0] func);
        return '{drive: m_unit, func: func, da: m_da[m_unit], dc: m_dc[m_unit],
                 wc: m_wc, ba: {2'b00, m_ba}};
    endfunction

    task automatic apply_write(input logic [REG_SEL_W-1:0] sel, input logic hi,
                               input logic lo, input logic [WORD_W-1:0] data);
        case (sel)
            REG_WC: m_wc = merge(m_wc, data, hi, lo);
            REG_BA: m_ba = merge(m_ba, {data[15:1], 1'b0}, hi, lo);
            REG_DA: m_da[m_unit] = merge(m_da[m_unit], data, hi, lo);
            REG_DC: m_dc[m_unit] = merge(m_dc[m_unit], data, hi, lo);
            REG_AS: if (lo) m_attn = m_attn & ~data[7:0];
            REG_CS1: if (hi && data[14]) m_pge = 1'b0;
            REG_CS2: if (lo) begin
                if (data[5]) begin                  // controller clear
                    for (int i = 0; i < NUM_DRIVES; i++) m_ds[i] = DS_RESET;
                    m_attn = '0;
                    m_unit = '0;
                    m_pge  = 1'b0;
                    m_wc   = '0;
                    m_ba   = '0;
                end else begin
                    m_unit = data[2:0];
                end
            end
            default: ;
        endcase
    endtask

    task automatic bus_cycle(input logic [REG_SEL_W-1:0] sel, input logic odd,
                             input logic [1:0] c, input logic [WORD_W-1:0] data,
                             output logic [WORD_W-1:0] rd);
        @(posedge CLOCK);
        a_in <= RH_BASE_ADDR + {sel, odd};
        c_in <= c;
        d_in <= data;
        msyn <= 1'b1;
        @(negedge CLOCK);
        check_bit("done_ready during access", 1'b0, done_ready);
        while (!ssyn) @(negedge CLOCK);
        rd = d_out;
        @(posedge CLOCK);
        msyn <= 1'b0;
        do @(negedge CLOCK); while (ssyn);
    endtask

    task automatic bus_write(input logic [REG_SEL_W-1:0] sel, input logic [WORD_W-1:0] data);
        logic [WORD_W-1:0] rd;
        bus_cycle(sel, 1'b0, 2'b10, data, rd);
        apply_write(sel, 1'b1, 1'b1, data);
    endtask

    task automatic write_byte(input logic [REG_SEL_W-1:0] sel, input logic odd,
                              input logic [WORD_W-1:0] data);
        logic [WORD_W-1:0] rd;
        bus_cycle(sel, odd, 2'b11, data, rd);
        apply_write(sel, odd, !odd, data);
    endtask

    task automatic bus_read(input logic [REG_SEL_W-1:0] sel, output logic [WORD_W-1:0] rd);
        bus_cycle(sel, 1'b0, 2'b00, '0, rd);
    endtask

    // read and queue the word for the comparing process
    task automatic read_expect(input logic [REG_SEL_W-1:0] sel, input string what);
        logic [WORD_W-1:0] rd;
        bus_read(sel, rd);
        exp_q.push_back(expected_word(sel));
        act_q.push_back(rd);
        name_q.push_back(what);
    endtask

    task automatic check_word(input string what, input logic [WORD_W-1:0] exp,
                              input logic [WORD_W-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s expected %h got %h", $time, what, exp, act);
        end
    endtask

    task automatic check_cmd(input disk_cmd_t exp, input disk_cmd_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: command expected %h got %h", $time, exp, act);
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s expected %b got %b", $time, what, exp, act);
        end
    endtask

    task automatic finish_test(input string name);
        @(posedge CLOCK);
        @(negedge CLOCK);
        tests++;
        $display("test %s: %s", name, (errors == test_start_errors) ? "ok" : "errors");
        test_start_errors = errors;
    endtask

    // comparing process
    always begin
        wait (act_q.size() != 0);
        check_word(name_q.pop_front(), exp_q.pop_front(), act_q.pop_front());
    end

    // disk engine: random ready, completions after random delays
    always @(posedge CLOCK) begin
        if (RESET) begin
            cmd_ready  <= 1'b0;
            done_valid <= 1'b0;
        end else begin
            cmd_ready <= lfsr_bit();
            if (cmd_valid && cmd_ready) begin
                cmd_log.push_back(cmd);
                pend_drive.push_back(cmd.drive);
                pend_wait.push_back(24 + int'(draw_bits(6)));
            end
            if (done_valid && done_ready) begin
                done_valid <= 1'b0;
                m_ds[done.drive][DS_DRY] = 1'b1;
                m_attn[done.drive] = 1'b1;
                void'(pend_drive.pop_front());
                void'(pend_wait.pop_front());
                done_count++;
            end else if (!done_valid && pend_wait.size() != 0) begin
                if (pend_wait[0] > 0) begin
                    pend_wait[0]--;
                end else begin
                    done_valid <= 1'b1;
                    done       <= {pend_drive[0], 1'b0};
                end
            end
        end
    end

    initial begin
        repeat (LIMIT_CYCLES) @(posedge CLOCK);
        $display("timeout: run did not end within %0d cycles", LIMIT_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        logic [WORD_W-1:0] rd;
        int                n_cmd;
        CLOCK = 1'b0;
        RESET = 1'b1;
        a_in = '0;
        c_in = '0;
        d_in = '0;
        msyn = 1'b0;
        cmd_ready = 1'b0;
        done_valid = 1'b0;
        done = '0;
        for (int i = 0; i < NUM_DRIVES; i++) m_ds[i] = DS_RESET;
        m_wc = '0;
        m_ba = '0;
        m_attn = '0;
        m_unit = '0;
        m_pge = 1'b0;
        repeat (16) @(posedge CLOCK);
        RESET <= 1'b0;

        bus_write(REG_WC, 16'o177400);
        write_byte(REG_WC, 1'b1, 16'hab00);
        bus_write(REG_BA, 16'h1235);                // bit 0 reads as zero
        bus_write(REG_DA, 16'h0102);
        bus_write(REG_DC, 16'h0033);
        bus_write(REG_CS2, 16'd3);
        bus_write(REG_DA, 16'h0a0b);
        bus_write(REG_DC, 16'h0100);
        write_byte(REG_DC, 1'b0, 16'h0055);
        read_expect(REG_WC, "WC");
        read_expect(REG_BA, "BA");
        read_expect(REG_DA, "DA unit 3");
        read_expect(REG_DC, "DC unit 3");
        bus_write(REG_CS2, 16'd0);
        read_expect(REG_DA, "DA unit 0");
        read_expect(REG_DC, "DC unit 0");
        finish_test("register access");

        bus_write(REG_CS2, 16'd3);
        n_cmd = cmd_log.size();
        bus_write(REG_CS1, 16'o000071);             // read data, GO
        wait (cmd_log.size() != n_cmd);
        check_cmd(expected_cmd(6'o71), cmd_log[$]);
        m_ds[3][DS_DRY] = 1'b0;
        bus_read(REG_CS1, rd);
        check_bit("CS1 RDY while busy", 1'b0, rd[7]);
        read_expect(REG_DS, "DS while busy");
        wait (done_count == 1);
        check_bit("one command", 1'b1, cmd_log.size() == n_cmd + 1);
        finish_test("data transfer GO");

        read_expect(REG_DS, "DS after completion");
        read_expect(REG_AS, "AS after completion");
        bus_read(REG_CS1, rd);
        check_bit("CS1 RDY", 1'b1, rd[7]);
        check_bit("CS1 SC", 1'b1, rd[15]);
        bus_write(REG_AS, 16'h0008);
        read_expect(REG_AS, "AS cleared");
        bus_read(REG_CS1, rd);
        check_bit("CS1 SC cleared", 1'b0, rd[15]);
        finish_test("completion");

        bus_write(REG_CS1, 16'o000005);             // seek
        m_ds[3][DS_DRY] = 1'b0;
        bus_write(REG_CS1, 16'o000071);             // drive busy
        m_pge = 1'b1;
        read_expect(REG_CS2, "CS2 with PGE");
        wait (done_count == 2);
        check_bit("no command for failed GO", 1'b1, cmd_log.size() == n_cmd + 2);
        bus_write(REG_CS1, 16'o040000);
        read_expect(REG_CS2, "CS2 after TRE");
        bus_write(REG_AS, 16'h0008);
        finish_test("busy drive");

        bus_write(REG_CS2, 16'd5);
        bus_write(REG_CS1, 16'o000023);             // pack acknowledge
        m_ds[5][DS_VV] = 1'b1;
        read_expect(REG_DS, "DS after pack acknowledge");
        check_bit("no command for pack acknowledge", 1'b1, cmd_log.size() == n_cmd + 2);
        check_bit("cmd_valid low", 1'b0, cmd_valid);
        finish_test("pack acknowledge");

        for (int i = 0; i < 6; i++) begin
            bus_read(REG_LA, rd);
            check_word("LA low bits", 16'h0000, rd & 16'hc00f);
            check_bit("LA sector in range", 1'b1, rd[13:6] < SECTORS_PER_TRACK);
            repeat (5 * i + 3) @(posedge CLOCK);
        end
        bus_write(REG_CS2, 16'o000040);             // controller clear
        read_expect(REG_WC, "WC after clear");
        bus_write(REG_CS2, 16'd5);
        read_expect(REG_DS, "DS unit 5 after clear");
        bus_write(REG_CS2, 16'd3);
        read_expect(REG_DS, "DS unit 3 after clear");
        finish_test("look-ahead and clear");

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== build.f ====
rtl/rh11_pkg.sv
rtl/rh11_bus_decode.sv
rtl/rh11_command.sv
rtl/rh11_drive_regs.sv
rtl/rh11_sector_counter.sv
rtl/rh11_read_mux.sv
rtl/rh11_top.sv
verification/rh11_assertions.sv
verification/tb_rh11.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_rh11
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wall

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q '^\*\*\* PASSED \*\*\*$$' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
